/* project.f */
source/cpu_pkg.sv
source/cpu_sequencer.sv
source/cpu_decoder.sv
source/cpu_program_counter.sv
source/cpu_registers.sv
source/cpu_bus_routing.sv
source/cpu_alu.sv
source/cpu_status.sv
source/cpu_6502.sv
verif/cpu_memory_model.sv
verif/cpu_6502_tb.sv

/* source/cpu_6502.sv */
module cpu_6502 (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic [7:0]        i_data,
    output logic              o_rw,
    output logic [15:0]       o_address,
    output logic [7:0]        o_data,
    output logic              o_sync,
    output cpu_pkg::debug_t   o_debug
);
    import cpu_pkg::*;

    // Internal buses
    logic [7:0] bus_db, bus_sb, bus_adl, bus_adh;

    logic [7:0] ir, p, dl, pcl, pch, ac, x, y, add;
    logic       acr, avr;
    tcu_e       tcu, tcu_next;
    ctrl_t      ctrl;

    cpu_sequencer seq0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_data(i_data), .i_tcu_next(tcu_next),
        .o_tcu(tcu), .o_ir(ir), .o_sync(o_sync)
    );

    cpu_decoder dec0 (
        .i_ir(ir), .i_tcu(tcu), .i_p(p), .o_ctrl(ctrl), .o_tcu_next(tcu_next)
    );

    cpu_program_counter pc0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_ctrl(ctrl), .i_adl(bus_adl), .i_adh(bus_adh),
        .o_pcl(pcl), .o_pch(pch)
    );

    cpu_registers regs0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_ctrl(ctrl), .i_data(i_data),
        .i_sb(bus_sb), .i_db(bus_db), .i_adl(bus_adl), .i_adh(bus_adh),
        .o_dl(dl), .o_ac(ac), .o_x(x), .o_y(y), .o_data(o_data), .o_address(o_address)
    );

    cpu_bus_routing route0 (
        .i_ctrl(ctrl), .i_dl(dl), .i_pcl(pcl), .i_pch(pch), .i_ac(ac), .i_x(x),
        .i_y(y), .i_add(add),
        .o_db(bus_db), .o_sb(bus_sb), .o_adl(bus_adl), .o_adh(bus_adh)
    );

    cpu_alu alu0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_ctrl(ctrl), .i_db(bus_db), .i_sb(bus_sb),
        .i_carry(p[P_C]), .o_add(add), .o_acr(acr), .o_avr(avr)
    );

    cpu_status status0 (
        .i_clk(i_clk), .i_rst(i_rst), .i_ctrl(ctrl), .i_sb(bus_sb),
        .i_acr(acr), .i_avr(avr), .o_p(p)
    );

    assign o_rw = ctrl.rw;

    // PC as the address bus registers show it, equal to the PC at every sync
    always_comb begin
        o_debug.ir  = ir;
        o_debug.tcu = tcu;
        o_debug.pc  = o_address;
        o_debug.ac  = ac;
        o_debug.x   = x;
        o_debug.y   = y;
        o_debug.p   = p;
    end

endmodule

/* source/cpu_alu.sv */
module cpu_alu (
    input  logic              i_clk,
    input  logic              i_rst,
    input  cpu_pkg::ctrl_t    i_ctrl,
    input  logic [7:0]        i_db,
    input  logic [7:0]        i_sb,
    input  logic              i_carry,
    output logic [7:0]        o_add,
    output logic              o_acr,
    output logic              o_avr
);
    import cpu_pkg::*;

    logic [7:0] a_in, b_in, result;
    logic [8:0] sum;
    logic       cin;
    logic       overflow;

    assign a_in = (i_ctrl.sb_add && !i_ctrl.zero_add) ? i_sb : 8'd0;
    assign b_in = i_ctrl.db_add ? i_db : 8'd0;

    // Two-operand sums take the carry flag, increments force it
    assign cin = i_ctrl.one_addc | (i_carry & i_ctrl.sb_add & i_ctrl.db_add);
    assign sum = {1'b0, a_in} + {1'b0, b_in} + {8'd0, cin};
    assign overflow = (a_in[7] == b_in[7]) && (sum[7] != a_in[7]);

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_AND: result = a_in & b_in;
            ALU_OR:  result = a_in | b_in;
            ALU_EOR: result = a_in ^ b_in;
            default: result = sum[7:0];
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_add <= 8'd0;
            o_acr <= 1'b0;
            o_avr <= 1'b0;
        end else begin
            o_add <= result;
            o_acr <= sum[8];
            o_avr <= overflow;
        end
    end

endmodule

/* source/cpu_bus_routing.sv */
module cpu_bus_routing (
    input  cpu_pkg::ctrl_t    i_ctrl,
    input  logic [7:0]        i_dl,
    input  logic [7:0]        i_pcl,
    input  logic [7:0]        i_pch,
    input  logic [7:0]        i_ac,
    input  logic [7:0]        i_x,
    input  logic [7:0]        i_y,
    input  logic [7:0]        i_add,
    output logic [7:0]        o_db,
    output logic [7:0]        o_sb,
    output logic [7:0]        o_adl,
    output logic [7:0]        o_adh
);
    import cpu_pkg::*;

    // Each bus is a wired OR, an idle bus reads zero
    always_comb begin
        o_db = ({8{i_ctrl.dl_db}} & i_dl)
             | ({8{i_ctrl.ac_db}} & i_ac);
    end

    always_comb begin
        o_sb = ({8{i_ctrl.ac_sb}} & i_ac)
             | ({8{i_ctrl.x_sb}} & i_x)
             | ({8{i_ctrl.y_sb}} & i_y)
             | ({8{i_ctrl.add_sb}} & i_add);
    end

    // Address low carries the PC, the data latch or the parked ALU byte
    always_comb begin
        o_adl = ({8{i_ctrl.dl_adl}} & i_dl)
              | ({8{i_ctrl.pcl_adl}} & i_pcl)
              | ({8{i_ctrl.add_adl}} & i_add);
    end

    always_comb begin
        o_adh = ({8{i_ctrl.dl_adh}} & i_dl)
              | ({8{i_ctrl.pch_adh}} & i_pch);
    end

endmodule

/* source/cpu_decoder.sv */
module cpu_decoder (
    input  logic [7:0]        i_ir,
    input  cpu_pkg::tcu_e     i_tcu,
    input  logic [7:0]        i_p,
    output cpu_pkg::ctrl_t    o_ctrl,
    output cpu_pkg::tcu_e     o_tcu_next
);
    import cpu_pkg::*;

    opcode_e op;
    ctrl_t   ctrl;
    tcu_e    tcu_next;

    always_comb begin
        op = opcode_e'(i_ir);
        ctrl = '0;
        ctrl.rw = 1'b1;
        ctrl.alu_op = ALU_SUM;
        tcu_next = T0;
        case (i_tcu)
            T0: begin
                // Opcode fetch, PC+1 goes to the address bus
                ctrl.i_pc    = 1'b1;
                ctrl.pcl_adl = 1'b1;
                ctrl.pch_adh = 1'b1;
                ctrl.adl_abl = 1'b1;
                ctrl.adh_abh = 1'b1;
                tcu_next     = T1;
                // IR still holds the previous opcode here, finish its writeback
                case (op)
                    LDA_IMM, ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM: begin
                        ctrl.add_sb = 1'b1;
                        ctrl.sb_ac  = 1'b1;
                        ctrl.nz_from_sb = 1'b1;
                    end
                    LDX_IMM, INX_IMP: begin
                        ctrl.add_sb = 1'b1;
                        ctrl.sb_x   = 1'b1;
                        ctrl.nz_from_sb = 1'b1;
                    end
                    LDY_IMM, INY_IMP: begin
                        ctrl.add_sb = 1'b1;
                        ctrl.sb_y   = 1'b1;
                        ctrl.nz_from_sb = 1'b1;
                    end
                    default: ;
                endcase
                if (op == ADC_IMM) begin
                    ctrl.acr_c = 1'b1;
                    ctrl.v_upd = 1'b1;
                end
            end
            T1: begin
                // Next address is the PC, bumped only when the operand byte is used
                ctrl.pcl_adl = 1'b1;
                ctrl.pch_adh = 1'b1;
                ctrl.adl_abl = 1'b1;
                ctrl.adh_abh = 1'b1;
                case (op)
                    LDA_IMM, LDX_IMM, LDY_IMM: begin
                        ctrl.i_pc     = 1'b1;
                        ctrl.dl_db    = 1'b1;
                        ctrl.db_add   = 1'b1;
                        ctrl.zero_add = 1'b1;
                    end
                    ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM: begin
                        ctrl.i_pc   = 1'b1;
                        ctrl.ac_sb  = 1'b1;
                        ctrl.sb_add = 1'b1;
                        ctrl.dl_db  = 1'b1;
                        ctrl.db_add = 1'b1;
                        case (op)
                            AND_IMM: ctrl.alu_op = ALU_AND;
                            ORA_IMM: ctrl.alu_op = ALU_OR;
                            EOR_IMM: ctrl.alu_op = ALU_EOR;
                            default: ctrl.alu_op = ALU_SUM;
                        endcase
                    end
                    TAX_IMP, TAY_IMP: begin
                        ctrl.ac_sb = 1'b1;
                        ctrl.sb_x  = (op == TAX_IMP);
                        ctrl.sb_y  = (op == TAY_IMP);
                        ctrl.nz_from_sb = 1'b1;
                    end
                    INX_IMP, INY_IMP: begin
                        ctrl.x_sb     = (op == INX_IMP);
                        ctrl.y_sb     = (op == INY_IMP);
                        ctrl.sb_add   = 1'b1;
                        ctrl.one_addc = 1'b1;
                    end
                    // Only strobe C when it actually changes
                    CLC_IMP: ctrl.c_clr = i_p[P_C];
                    SEC_IMP: ctrl.c_set = ~i_p[P_C];
                    JMP_ABS, STA_ABS: begin
                        // Park the low address byte in the ALU
                        ctrl.i_pc     = 1'b1;
                        ctrl.dl_db    = 1'b1;
                        ctrl.db_add   = 1'b1;
                        ctrl.zero_add = 1'b1;
                        tcu_next      = T2;
                    end
                    default: ;
                endcase
            end
            T2: begin
                // High byte straight from the data latch, low byte from the ALU
                ctrl.dl_adh  = 1'b1;
                ctrl.add_adl = 1'b1;
                ctrl.adl_abl = 1'b1;
                ctrl.adh_abh = 1'b1;
                if (op == STA_ABS) begin
                    ctrl.i_pc   = 1'b1;
                    ctrl.ac_db  = 1'b1;
                    ctrl.db_dor = 1'b1;
                    tcu_next    = T3;
                end else begin
                    ctrl.adl_pcl = 1'b1;
                    ctrl.adh_pch = 1'b1;
                end
            end
            T3: begin
                // Write cycle, PC goes back onto the address bus for the next fetch
                ctrl.rw      = 1'b0;
                ctrl.pcl_adl = 1'b1;
                ctrl.pch_adh = 1'b1;
                ctrl.adl_abl = 1'b1;
                ctrl.adh_abh = 1'b1;
            end
            default: ;
        endcase
    end

    assign o_ctrl     = ctrl;
    assign o_tcu_next = tcu_next;

endmodule

/* source/cpu_pkg.sv */
package cpu_pkg;

    // Start address after reset, no vector fetch
    localparam logic [15:0] RESET_PC = 16'h0200;

    // Flag positions inside P
    localparam int P_N = 7;
    localparam int P_V = 6;
    localparam int P_Z = 1;
    localparam int P_C = 0;

    // Supported opcodes at their 6502 byte values
    typedef enum logic [7:0] {
        ORA_IMM = 8'h09,
        CLC_IMP = 8'h18,
        AND_IMM = 8'h29,
        SEC_IMP = 8'h38,
        EOR_IMM = 8'h49,
        JMP_ABS = 8'h4C,
        ADC_IMM = 8'h69,
        STA_ABS = 8'h8D,
        LDY_IMM = 8'hA0,
        LDX_IMM = 8'hA2,
        TAY_IMP = 8'hA8,
        LDA_IMM = 8'hA9,
        TAX_IMP = 8'hAA,
        INY_IMP = 8'hC8,
        INX_IMP = 8'hE8,
        NOP_IMP = 8'hEA
    } opcode_e;

    typedef enum logic [1:0] {T0, T1, T2, T3} tcu_e;

    typedef enum logic [1:0] {ALU_SUM, ALU_AND, ALU_OR, ALU_EOR} alu_op_e;

    // Decoder strobes, one bit per bus transfer
    typedef struct packed {
        logic    rw;
        logic    dl_db, dl_adl, dl_adh, pcl_adl, pch_adh, ac_db;
        logic    ac_sb, x_sb, y_sb, add_sb, add_adl;
        logic    sb_ac, sb_x, sb_y, adl_abl, adh_abh, adl_pcl, adh_pch, i_pc;
        logic    db_add, sb_add, zero_add, one_addc, acr_c;
        alu_op_e alu_op;
        logic    nz_from_sb, c_set, c_clr, v_upd;
        logic    db_dor;
    } ctrl_t;

    typedef struct packed {
        logic [7:0]  ir;
        tcu_e        tcu;
        logic [15:0] pc;
        logic [7:0]  ac;
        logic [7:0]  x;
        logic [7:0]  y;
        logic [7:0]  p;
    } debug_t;

endpackage

/* source/cpu_program_counter.sv */
module cpu_program_counter (
    input  logic              i_clk,
    input  logic              i_rst,
    input  cpu_pkg::ctrl_t    i_ctrl,
    input  logic [7:0]        i_adl,
    input  logic [7:0]        i_adh,
    output logic [7:0]        o_pcl,
    output logic [7:0]        o_pch
);
    import cpu_pkg::*;

    logic [7:0] pcl;
    logic [7:0] pch;
    logic [7:0] pcl_inc;
    logic [7:0] pch_inc;
    logic       pclc;

    // Incrementer sits in front of the bus drivers
    assign {pclc, pcl_inc} = {1'b0, pcl} + {8'd0, i_ctrl.i_pc};
    assign pch_inc = pch + {7'd0, pclc};

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pcl <= RESET_PC[7:0];
            pch <= RESET_PC[15:8];
        end else if (i_ctrl.i_pc) begin
            pcl <= pcl_inc;
            pch <= pch_inc;
        end else begin
            if (i_ctrl.adl_pcl) begin
                pcl <= i_adl;
            end
            if (i_ctrl.adh_pch) begin
                pch <= i_adh;
            end
        end
    end

    assign o_pcl = pcl_inc;
    assign o_pch = pch_inc;

endmodule

/* source/cpu_registers.sv */
module cpu_registers (
    input  logic              i_clk,
    input  logic              i_rst,
    input  cpu_pkg::ctrl_t    i_ctrl,
    input  logic [7:0]        i_data,
    input  logic [7:0]        i_sb,
    input  logic [7:0]        i_db,
    input  logic [7:0]        i_adl,
    input  logic [7:0]        i_adh,
    output logic [7:0]        o_dl,
    output logic [7:0]        o_ac,
    output logic [7:0]        o_x,
    output logic [7:0]        o_y,
    output logic [7:0]        o_data,
    output logic [15:0]       o_address
);
    import cpu_pkg::*;

    logic [7:0] ac, x, y, dor, abl, abh;

    // Input data latch is transparent while memory answers
    assign o_dl = i_data;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ac  <= 8'd0;
            x   <= 8'd0;
            y   <= 8'd0;
            abl <= RESET_PC[7:0];
            abh <= RESET_PC[15:8];
        end else begin
            if (i_ctrl.sb_ac) ac <= i_sb;
            if (i_ctrl.sb_x) x <= i_sb;
            if (i_ctrl.sb_y) y <= i_sb;
            if (i_ctrl.adl_abl) abl <= i_adl;
            if (i_ctrl.adh_abh) abh <= i_adh;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_ctrl.db_dor) begin
            dor <= i_db;
        end
    end

    assign o_ac      = ac;
    assign o_x       = x;
    assign o_y       = y;
    assign o_data    = dor;
    assign o_address = {abh, abl};

endmodule

/* source/cpu_sequencer.sv */
module cpu_sequencer (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic [7:0]        i_data,
    input  cpu_pkg::tcu_e     i_tcu_next,
    output cpu_pkg::tcu_e     o_tcu,
    output logic [7:0]        o_ir,
    output logic              o_sync
);
    import cpu_pkg::*;

    tcu_e       tcu;
    logic [7:0] ir;

    // Cycle counter
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            tcu <= T0;
        end else begin
            tcu <= i_tcu_next;
        end
    end

    // Opcode is on the data bus during T0, so IR holds it from T1 on
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ir <= NOP_IMP;
        end else if (tcu == T0) begin
            ir <= i_data;
        end
    end

    assign o_tcu  = tcu;
    assign o_ir   = ir;
    assign o_sync = (tcu == T0);

endmodule

/* source/cpu_status.sv */
module cpu_status (
    input  logic              i_clk,
    input  logic              i_rst,
    input  cpu_pkg::ctrl_t    i_ctrl,
    input  logic [7:0]        i_sb,
    input  logic              i_acr,
    input  logic              i_avr,
    output logic [7:0]        o_p
);
    import cpu_pkg::*;

    logic [7:0] p;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            p <= 8'd0;
        end else begin
            if (i_ctrl.nz_from_sb) begin
                p[P_N] <= i_sb[7];
                p[P_Z] <= (i_sb == 8'd0);
            end
            // Explicit set and clear win over the ALU carry
            if (i_ctrl.c_set) begin
                p[P_C] <= 1'b1;
            end else if (i_ctrl.c_clr) begin
                p[P_C] <= 1'b0;
            end else if (i_ctrl.acr_c) begin
                p[P_C] <= i_acr;
            end
            if (i_ctrl.v_upd) begin
                p[P_V] <= i_avr;
            end
        end
    end

    assign o_p = p;

endmodule

/* verif/cpu_6502_tb.sv */
module cpu_6502_tb;
    import cpu_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 4;
    localparam int RANDOM_COUNT = 200;

    logic        clk;
    logic        rst;
    logic        rw;
    logic        sync;
    logic [15:0] address;
    logic [7:0]  data_to_cpu;
    logic [7:0]  data_from_cpu;
    debug_t      dbg;

    // Reference state, stepped one instruction at a time
    logic [15:0] m_pc;
    logic [7:0]  m_a, m_x, m_y, m_p;
    logic [7:0]  ref_mem [0:65535];

    logic [15:0] wp;
    int          n_instr;
    logic        prog_ready;

    logic [7:0] op_table [16] = '{
        LDA_IMM, LDX_IMM, LDY_IMM, ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM, TAX_IMP,
        TAY_IMP, INX_IMP, INY_IMP, CLC_IMP, SEC_IMP, STA_ABS, JMP_ABS, NOP_IMP
    };

    cpu_6502 dut0 (
        .i_clk(clk), .i_rst(rst), .i_data(data_to_cpu), .o_rw(rw),
        .o_address(address), .o_data(data_from_cpu), .o_sync(sync), .o_debug(dbg)
    );

    cpu_memory_model mem0 (
        .i_clk(clk), .i_rw(rw), .i_address(address), .i_data(data_from_cpu),
        .o_data(data_to_cpu)
    );

    always #(CLK_HALF) clk = ~clk;

    task automatic stop_with_failure();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped after the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
        stop_with_failure();
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    function automatic int instr_len(input logic [7:0] op);
        case (op)
            STA_ABS, JMP_ABS: return 3;
            LDA_IMM, LDX_IMM, LDY_IMM, ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM: return 2;
            default: return 1;
        endcase
    endfunction

    task automatic put_byte(input logic [7:0] b);
        ref_mem[wp]  = b;
        mem0.mem[wp] = b;
        wp = wp + 16'd1;
    endtask

    task automatic put_instr(input logic [7:0] op, input logic [15:0] arg);
        int len;
        len = instr_len(op);
        put_byte(op);
        if (len > 1) put_byte(arg[7:0]);
        if (len > 2) put_byte(arg[15:8]);
        n_instr++;
    endtask

    function automatic logic [7:0] with_nz(input logic [7:0] p, input logic [7:0] v);
        logic [7:0] r;
        r = p;
        r[P_N] = v[7];
        r[P_Z] = (v == 8'd0);
        return r;
    endfunction

    // Executes one instruction on the model, returns its cycle count
    function automatic int step_model(output logic wr, output logic [15:0] wa,
                                      output logic [7:0] wd);
        logic [7:0] op, lo, hi;
        logic [8:0] s;
        int         cyc;
        op  = ref_mem[m_pc];
        lo  = ref_mem[m_pc + 16'd1];
        hi  = ref_mem[m_pc + 16'd2];
        wr  = 1'b0;
        wa  = 16'd0;
        wd  = 8'd0;
        cyc = 2;
        m_pc = m_pc + 16'(instr_len(op));
        case (op)
            LDA_IMM: m_a = lo;
            LDX_IMM: m_x = lo;
            LDY_IMM: m_y = lo;
            AND_IMM: m_a = m_a & lo;
            ORA_IMM: m_a = m_a | lo;
            EOR_IMM: m_a = m_a ^ lo;
            TAX_IMP: m_x = m_a;
            TAY_IMP: m_y = m_a;
            INX_IMP: m_x = m_x + 8'd1;
            INY_IMP: m_y = m_y + 8'd1;
            CLC_IMP: m_p[P_C] = 1'b0;
            SEC_IMP: m_p[P_C] = 1'b1;
            ADC_IMM: begin
                s = {1'b0, m_a} + {1'b0, lo} + {8'd0, m_p[P_C]};
                // Signed overflow when both operands differ in sign from the sum
                m_p[P_V] = ((m_a ^ s[7:0]) & (lo ^ s[7:0]) & 8'h80) != 8'd0;
                m_p[P_C] = s[8];
                m_a = s[7:0];
            end
            STA_ABS: begin
                wr  = 1'b1;
                wa  = {hi, lo};
                wd  = m_a;
                cyc = 4;
                ref_mem[wa] = m_a;
            end
            JMP_ABS: begin
                m_pc = {hi, lo};
                cyc  = 3;
            end
            default: ;
        endcase
        case (op)
            LDA_IMM, AND_IMM, ORA_IMM, EOR_IMM, ADC_IMM: m_p = with_nz(m_p, m_a);
            LDX_IMM, TAX_IMP, INX_IMP: m_p = with_nz(m_p, m_x);
            LDY_IMM, TAY_IMP, INY_IMP: m_p = with_nz(m_p, m_y);
            default: ;
        endcase
        return cyc;
    endfunction

    initial begin
        wait (prog_ready);
        #(2 * CLK_HALF * (4 * n_instr + 100 + RESET_CYCLES));
        $display("Watchdog timeout: program of %0d instructions did not finish", n_instr);
        stop_with_failure();
    end

    initial begin
        logic [7:0]  op;
        logic [15:0] arg;
        logic        wr;
        logic [15:0] wa;
        logic [7:0]  wd;
        logic [7:0]  pre_a, pre_x, pre_y, pre_p;
        int          cyc;
        clk        = 1'b0;
        rst        = 1'b1;
        prog_ready = 1'b0;
        n_instr    = 0;
        void'($urandom(32'h3624_e787));
        m_pc = RESET_PC;
        m_a  = 8'd0;
        m_x  = 8'd0;
        m_y  = 8'd0;
        m_p  = 8'd0;
        for (int a = 0; a < 65536; a++) begin
            ref_mem[a]  = 8'(a) ^ 8'(a >> 8) ^ 8'hA5;
            mem0.mem[a] = ref_mem[a];
        end

        // Directed section, overflow, carry in, zero results and wraparound
        wp = RESET_PC;
        put_instr(LDA_IMM, 16'h007F);
        put_instr(ADC_IMM, 16'h0001);
        put_instr(SEC_IMP, 16'h0000);
        put_instr(LDA_IMM, 16'h00FF);
        put_instr(ADC_IMM, 16'h0001);
        put_instr(CLC_IMP, 16'h0000);
        put_instr(LDA_IMM, 16'h00FF);
        put_instr(ADC_IMM, 16'h0001);
        put_instr(AND_IMM, 16'h0000);
        put_instr(LDX_IMM, 16'h00FF);
        put_instr(INX_IMP, 16'h0000);
        put_instr(LDY_IMM, 16'h00FF);
        put_instr(INY_IMP, 16'h0000);
        put_instr(LDA_IMM, 16'h0080);
        put_instr(TAX_IMP, 16'h0000);
        put_instr(TAY_IMP, 16'h0000);
        put_instr(EOR_IMM, 16'h00FF);
        put_instr(ORA_IMM, 16'h0000);
        put_instr(STA_ABS, 16'h8012);
        put_instr(NOP_IMP, 16'h0000);
        put_instr(JMP_ABS, wp + 16'd3);
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            op = op_table[$urandom_range(15, 0)];
            if (op == JMP_ABS) arg = wp + 16'd3;
            else if (op == STA_ABS) arg = {8'h80, 8'($urandom)};
            else arg = 16'($urandom);
            put_instr(op, arg);
        end
        put_instr(JMP_ABS, wp);
        prog_ready = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        check_value("o_debug.ac", dbg.ac, 16'd0);
        check_value("o_debug.x", dbg.x, 16'd0);
        check_value("o_debug.y", dbg.y, 16'd0);
        check_value("o_debug.p", dbg.p, 16'd0);

        // Final self jump runs twice so the last results are compared
        for (int k = 0; k < n_instr + 1; k++) begin
            check_value("o_sync", sync, 16'd1);
            check_value("o_address", address, m_pc);
            check_value("o_rw", rw, 16'd1);
            op    = ref_mem[m_pc];
            pre_a = m_a;
            pre_x = m_x;
            pre_y = m_y;
            pre_p = m_p;
            cyc = step_model(wr, wa, wd);
            for (int c = 1; c < cyc; c++) begin
                @(negedge clk);
                check_value("o_sync", sync, 16'd0);
                check_value("o_debug.tcu", dbg.tcu, 16'(c));
                if (c == 1) begin
                    // Previous instruction has finished its writeback by now
                    check_value("o_debug.ir", dbg.ir, op);
                    check_value("o_debug.ac", dbg.ac, pre_a);
                    check_value("o_debug.x", dbg.x, pre_x);
                    check_value("o_debug.y", dbg.y, pre_y);
                    check_value("o_debug.p", dbg.p, pre_p);
                end
                if (wr && c == 3) begin
                    check_value("o_rw", rw, 16'd0);
                    check_value("o_address", address, wa);
                    check_value("o_data", data_from_cpu, wd);
                end else begin
                    check_value("o_rw", rw, 16'd1);
                end
            end
            @(negedge clk);
        end

        check_value("o_sync", sync, 16'd1);
        check_value("o_debug.pc", dbg.pc, m_pc);
        check_value("o_debug.ac", dbg.ac, m_a);
        check_value("o_debug.x", dbg.x, m_x);
        check_value("o_debug.y", dbg.y, m_y);
        check_value("o_debug.p", dbg.p, m_p);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* verif/cpu_memory_model.sv */
module cpu_memory_model (
    input  logic        i_clk,
    input  logic        i_rw,
    input  logic [15:0] i_address,
    input  logic [7:0]  i_data,
    output logic [7:0]  o_data
);

    // Full 64 KiB address space
    logic [7:0] mem [0:65535];

    // Reads answer in the same cycle
    assign o_data = mem[i_address];

    always @(posedge i_clk) begin
        if (!i_rw) begin
            mem[i_address] <= i_data;
        end
    end

endmodule
